/* src/pid_consts.svh */
`ifndef PID_CONSTS_SVH
`define PID_CONSTS_SVH

// ----------------------------------------
// Channel geometry
// ----------------------------------------
`define PID_N_CHAN 8
`define PID_W_CHAN 3

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define PID_W_SAMPLE 18
`define PID_W_COEF 16
`define PID_W_DOUT 32
`define PID_W_CFG 32

// Downstream buffer depth, also the credits held at reset
`define PID_OUT_CREDITS 4
`define PID_W_CREDIT 4

`endif

/* src/pid_pkg.sv */
`include "pid_consts.svh"

package pid_pkg;

    // ----------------------------------------
    // Scalar datapath types
    // ----------------------------------------
    typedef logic [`PID_W_CHAN-1:0] chan_t;
    typedef logic signed [`PID_W_SAMPLE-1:0] sample_t;
    typedef logic signed [`PID_W_COEF-1:0] coef_t;

    // k1 needs two growth bits over a single coefficient
    typedef logic signed [`PID_W_COEF+1:0] kcoef_t;

    // One extra bit for setpoint minus sample
    typedef logic signed [`PID_W_SAMPLE:0] error_t;

    // Full product width of kcoef_t times error_t
    typedef logic signed [`PID_W_SAMPLE+`PID_W_COEF+2:0] prod_t;

    // Sum of three products, two guard bits
    typedef logic signed [`PID_W_SAMPLE+`PID_W_COEF+4:0] delta_t;

    typedef logic signed [`PID_W_DOUT-1:0] dout_t;

    // ----------------------------------------
    // Configuration map
    // ----------------------------------------
    typedef enum logic [2:0] {
        SETPOINT  = 3'd0,
        P_COEF    = 3'd1,
        I_COEF    = 3'd2,
        D_COEF    = 3'd3,
        INV_ERROR = 3'd4,
        CLEAR     = 3'd5
    } cfg_addr_e;

    // Same data word, read by address as setpoint or coefficient
    typedef union packed {
        struct packed {
            logic [`PID_W_CFG-`PID_W_SAMPLE-1:0] pad;
            sample_t setpoint;
        } as_sample;
        struct packed {
            logic [`PID_W_CFG-`PID_W_COEF-1:0] pad;
            coef_t coef;   // bit 0 doubles as the flag for INV_ERROR and CLEAR
        } as_coef;
    } pid_cfg_word_u;

endpackage

/* src/pid_stage_if.sv */
`timescale 1ns/1ps

// Fetch stage payload with the sample and its channel's configuration
interface pid_fetch_if;
    logic valid;
    logic voided;
    pid_pkg::chan_t chan;
    pid_pkg::sample_t sample;
    pid_pkg::sample_t setpoint;
    pid_pkg::coef_t p_coef;
    pid_pkg::coef_t i_coef;
    pid_pkg::coef_t d_coef;
    logic inv_error;

    modport src (output valid, voided, chan, sample, setpoint,
                 p_coef, i_coef, d_coef, inv_error);
    modport dst (input valid, voided, chan, sample, setpoint,
                 p_coef, i_coef, d_coef, inv_error);
endinterface

// Product stage payload carrying three coefficient-error products
interface pid_prod_if;
    logic valid;
    logic voided;
    pid_pkg::chan_t chan;
    pid_pkg::prod_t prod1;
    pid_pkg::prod_t prod2;
    pid_pkg::prod_t prod3;

    modport src (output valid, voided, chan, prod1, prod2, prod3);
    modport dst (input valid, voided, chan, prod1, prod2, prod3);
endinterface

/* src/pid_config.sv */
`timescale 1ns/1ps
`include "pid_consts.svh"

module pid_config (
    input  logic                  clk_in,
    input  logic                  rst_n,
    output logic                  in_credit,
    input  logic                  in_valid,
    input  pid_pkg::chan_t        in_chan,
    input  pid_pkg::sample_t      in_sample,
    input  logic                  cfg_valid,
    input  pid_pkg::cfg_addr_e    cfg_addr,
    input  pid_pkg::chan_t        cfg_chan,
    input  pid_pkg::pid_cfg_word_u cfg_data,
    input  logic                  out_credit,
    input  logic                  credit_refund,
    output logic                  clear_valid,
    output pid_pkg::chan_t        clear_chan,
    pid_fetch_if.src              fetch
);

    // ----------------------------------------
    // Per-channel configuration
    // ----------------------------------------
    pid_pkg::sample_t setpoint_mem [`PID_N_CHAN];
    pid_pkg::coef_t   p_coef_mem   [`PID_N_CHAN];
    pid_pkg::coef_t   i_coef_mem   [`PID_N_CHAN];
    pid_pkg::coef_t   d_coef_mem   [`PID_N_CHAN];
    logic [`PID_N_CHAN-1:0] inv_error_mem;

    logic cfg_flag;
    assign cfg_flag = cfg_data.as_coef.coef[0];

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            for (int i = 0; i < `PID_N_CHAN; i++) begin
                setpoint_mem[i] <= '0;
                p_coef_mem[i] <= '0;
                i_coef_mem[i] <= '0;
                d_coef_mem[i] <= '0;
            end
            inv_error_mem <= '0;
        end else if (cfg_valid) begin
            // Address picks the union view
            case (cfg_addr)
                pid_pkg::SETPOINT:  setpoint_mem[cfg_chan] <= cfg_data.as_sample.setpoint;
                pid_pkg::P_COEF:    p_coef_mem[cfg_chan] <= cfg_data.as_coef.coef;
                pid_pkg::I_COEF:    i_coef_mem[cfg_chan] <= cfg_data.as_coef.coef;
                pid_pkg::D_COEF:    d_coef_mem[cfg_chan] <= cfg_data.as_coef.coef;
                pid_pkg::INV_ERROR: inv_error_mem[cfg_chan] <= cfg_flag;
                default: ;
            endcase
        end
    end

    // Clear strobe one cycle after the CLEAR write
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            clear_valid <= 1'b0;
        end else begin
            clear_valid <= cfg_valid && (cfg_addr == pid_pkg::CLEAR) && cfg_flag;
        end
        clear_chan <= cfg_chan;
    end

    // ----------------------------------------
    // Credit pool
    // ----------------------------------------
    logic [`PID_W_CREDIT-1:0] credit_cnt;
    logic credit_issue;

    // Hand out one credit per cycle while any are pooled
    assign credit_issue = (credit_cnt != '0);

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            credit_cnt <= `PID_OUT_CREDITS;
            in_credit <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt
                        + {{(`PID_W_CREDIT-1){1'b0}}, out_credit}
                        + {{(`PID_W_CREDIT-1){1'b0}}, credit_refund}
                        - {{(`PID_W_CREDIT-1){1'b0}}, credit_issue};
            in_credit <= credit_issue;
        end
    end

    // ----------------------------------------
    // Stage 1 fetch
    // ----------------------------------------
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            fetch.valid <= 1'b0;
        end else begin
            fetch.valid <= in_valid;
        end
        // Sample arriving during its channel's clear is dead on entry
        fetch.voided <= clear_valid && (in_chan == clear_chan);
        fetch.chan <= in_chan;
        fetch.sample <= in_sample;
        fetch.setpoint <= setpoint_mem[in_chan];
        fetch.p_coef <= p_coef_mem[in_chan];
        fetch.i_coef <= i_coef_mem[in_chan];
        fetch.d_coef <= d_coef_mem[in_chan];
        fetch.inv_error <= inv_error_mem[in_chan];
    end

endmodule

/* src/pid_error_stage.sv */
`timescale 1ns/1ps
`include "pid_consts.svh"

module pid_error_stage (
    input  logic           clk_in,
    input  logic           rst_n,
    input  logic           clear_valid,
    input  pid_pkg::chan_t clear_chan,
    pid_fetch_if.dst       fetch,
    pid_prod_if.src        prod
);

    // Error history holding e[n-1] and e[n-2] per channel
    pid_pkg::error_t err1_mem [`PID_N_CHAN];
    pid_pkg::error_t err2_mem [`PID_N_CHAN];

    // ----------------------------------------
    // Stage 2 error and k coefficients
    // ----------------------------------------
    pid_pkg::error_t err_raw;
    pid_pkg::error_t err_next;

    assign err_raw = pid_pkg::error_t'(fetch.setpoint) - pid_pkg::error_t'(fetch.sample);
    // Ones' complement rather than negation
    assign err_next = fetch.inv_error ? ~err_raw : err_raw;

    logic s2_valid;
    logic s2_void;
    pid_pkg::chan_t s2_chan;
    pid_pkg::error_t s2_err;
    pid_pkg::error_t s2_err1;
    pid_pkg::error_t s2_err2;
    pid_pkg::kcoef_t s2_k1;
    pid_pkg::kcoef_t s2_k2;
    pid_pkg::kcoef_t s2_k3;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= fetch.valid;
        end
        s2_void <= fetch.voided || (clear_valid && (fetch.chan == clear_chan));
        s2_chan <= fetch.chan;
        s2_err <= err_next;
        s2_err1 <= err1_mem[fetch.chan];
        s2_err2 <= err2_mem[fetch.chan];
        // k1 = p+i+d, k2 = -p-2d, k3 = d
        s2_k1 <= pid_pkg::kcoef_t'(fetch.p_coef) + pid_pkg::kcoef_t'(fetch.i_coef)
               + pid_pkg::kcoef_t'(fetch.d_coef);
        s2_k2 <= -pid_pkg::kcoef_t'(fetch.p_coef) - (pid_pkg::kcoef_t'(fetch.d_coef) <<< 1);
        s2_k3 <= pid_pkg::kcoef_t'(fetch.d_coef);
    end

    // ----------------------------------------
    // Stage 3 products and history writeback
    // ----------------------------------------
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            prod.valid <= 1'b0;
        end else begin
            prod.valid <= s2_valid;
        end
        prod.voided <= s2_void || (clear_valid && (s2_chan == clear_chan));
        prod.chan <= s2_chan;
        prod.prod1 <= pid_pkg::prod_t'(s2_k1) * pid_pkg::prod_t'(s2_err);
        prod.prod2 <= pid_pkg::prod_t'(s2_k2) * pid_pkg::prod_t'(s2_err1);
        prod.prod3 <= pid_pkg::prod_t'(s2_k3) * pid_pkg::prod_t'(s2_err2);
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            for (int i = 0; i < `PID_N_CHAN; i++) begin
                err1_mem[i] <= '0;
                err2_mem[i] <= '0;
            end
        end else begin
            // Shift history as the item leaves stage 2
            if (s2_valid && !s2_void) begin
                err1_mem[s2_chan] <= s2_err;
                err2_mem[s2_chan] <= s2_err1;
            end
            // Clear wins over a same-channel writeback
            if (clear_valid) begin
                err1_mem[clear_chan] <= '0;
                err2_mem[clear_chan] <= '0;
            end
        end
    end

endmodule

/* src/pid_accum_stage.sv */
`timescale 1ns/1ps
`include "pid_consts.svh"

module pid_accum_stage (
    input  logic           clk_in,
    input  logic           rst_n,
    input  logic           clear_valid,
    input  pid_pkg::chan_t clear_chan,
    pid_prod_if.dst        prod,
    output logic           out_valid,
    output pid_pkg::chan_t out_chan,
    output pid_pkg::dout_t out_data,
    output logic           credit_refund
);

    // Wide enough for prev output plus delta without wrap
    localparam int W_SUM = $bits(pid_pkg::delta_t) + 1;
    localparam pid_pkg::dout_t DOUT_MAX = {1'b0, {(`PID_W_DOUT-1){1'b1}}};
    localparam pid_pkg::dout_t DOUT_MIN = {1'b1, {(`PID_W_DOUT-1){1'b0}}};

    // Previous output per channel
    pid_pkg::dout_t dout_mem [`PID_N_CHAN];

    // ----------------------------------------
    // Stage 4 delta and previous output
    // ----------------------------------------
    logic s4_valid;
    logic s4_void;
    pid_pkg::chan_t s4_chan;
    pid_pkg::delta_t s4_delta;
    pid_pkg::dout_t s4_prev;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            s4_valid <= 1'b0;
        end else begin
            s4_valid <= prod.valid;
        end
        s4_void <= prod.voided || (clear_valid && (prod.chan == clear_chan));
        s4_chan <= prod.chan;
        s4_delta <= pid_pkg::delta_t'(prod.prod1) + pid_pkg::delta_t'(prod.prod2)
                  + pid_pkg::delta_t'(prod.prod3);
        s4_prev <= dout_mem[prod.chan];
    end

    // ----------------------------------------
    // Stage 5 sums, saturates and presents
    // ----------------------------------------
    logic signed [W_SUM-1:0] sum_wide;
    pid_pkg::dout_t dout_sat;
    logic s5_void;

    assign sum_wide = W_SUM'(s4_delta) + W_SUM'(s4_prev);

    // Clamp to the 32-bit signed range
    always_comb begin
        if (sum_wide > W_SUM'(DOUT_MAX)) begin
            dout_sat = DOUT_MAX;
        end else if (sum_wide < W_SUM'(DOUT_MIN)) begin
            dout_sat = DOUT_MIN;
        end else begin
            dout_sat = sum_wide[`PID_W_DOUT-1:0];
        end
    end

    assign s5_void = s4_void || (clear_valid && (s4_chan == clear_chan));

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            credit_refund <= 1'b0;
        end else begin
            out_valid <= s4_valid && !s5_void;
            // Voided item hands its output slot back
            credit_refund <= s4_valid && s5_void;
        end
        out_chan <= s4_chan;
        out_data <= dout_sat;
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            for (int i = 0; i < `PID_N_CHAN; i++) begin
                dout_mem[i] <= '0;
            end
        end else begin
            if (s4_valid && !s4_void) begin
                dout_mem[s4_chan] <= dout_sat;
            end
            // Clear overrides same-channel writeback
            if (clear_valid) begin
                dout_mem[clear_chan] <= '0;
            end
        end
    end

endmodule

/* src/pid_top.sv */
`timescale 1ns/1ps

module pid_top (
    input  logic                   clk_in,
    input  logic                   rst_n,
    // Upstream samples
    output logic                   in_credit,
    input  logic                   in_valid,
    input  pid_pkg::chan_t         in_chan,
    input  pid_pkg::sample_t       in_sample,
    // Configuration writes
    input  logic                   cfg_valid,
    input  pid_pkg::cfg_addr_e     cfg_addr,
    input  pid_pkg::chan_t         cfg_chan,
    input  pid_pkg::pid_cfg_word_u cfg_data,
    // Downstream results
    output logic                   out_valid,
    output pid_pkg::chan_t         out_chan,
    output pid_pkg::dout_t         out_data,
    input  logic                   out_credit
);

    // ----------------------------------------
    // Inter-stage wiring
    // ----------------------------------------
    logic clear_valid;
    pid_pkg::chan_t clear_chan;
    logic credit_refund;

    pid_fetch_if i_fetch_if ();
    pid_prod_if i_prod_if ();

    // Config, credits, stage 1
    pid_config i_config (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .in_credit     (in_credit),
        .in_valid      (in_valid),
        .in_chan       (in_chan),
        .in_sample     (in_sample),
        .cfg_valid     (cfg_valid),
        .cfg_addr      (cfg_addr),
        .cfg_chan      (cfg_chan),
        .cfg_data      (cfg_data),
        .out_credit    (out_credit),
        .credit_refund (credit_refund),
        .clear_valid   (clear_valid),
        .clear_chan    (clear_chan),
        .fetch         (i_fetch_if.src)
    );

    // Stages 2 and 3
    pid_error_stage i_error_stage (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .clear_valid (clear_valid),
        .clear_chan  (clear_chan),
        .fetch       (i_fetch_if.dst),
        .prod        (i_prod_if.src)
    );

    // Stages 4 and 5
    pid_accum_stage i_accum_stage (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .clear_valid   (clear_valid),
        .clear_chan    (clear_chan),
        .prod          (i_prod_if.dst),
        .out_valid     (out_valid),
        .out_chan      (out_chan),
        .out_data      (out_data),
        .credit_refund (credit_refund)
    );

endmodule

/* sim/pid_props.sv */
`timescale 1ns/1ps

module pid_props (
    input logic       clk_in,
    input logic       rst_n,
    input logic       in_valid,
    input logic       in_credit,
    input logic       out_valid,
    input logic       cfg_valid,
    input logic [2:0] cfg_addr
);

    // Nothing leaves the DUT while reset is held
    reset_quiet: assert property (@(posedge clk_in)
        (!rst_n && $past(!rst_n)) |-> (!out_valid && !in_credit))
        else $error("out_valid or in_credit high during reset");

    // Every result traces back to a sample five cycles earlier
    output_has_sample: assert property (@(posedge clk_in) disable iff (!rst_n)
        out_valid |-> $past(in_valid, 5))
        else $error("out_valid without a sample five cycles earlier");

    // Only the six mapped configuration addresses
    cfg_addr_known: assert property (@(posedge clk_in) disable iff (!rst_n)
        cfg_valid |-> (cfg_addr <= 3'd5))
        else $error("configuration write to an unmapped address");

endmodule

bind pid_top pid_props i_pid_props (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_credit (in_credit),
    .out_valid (out_valid),
    .cfg_valid (cfg_valid),
    .cfg_addr  (cfg_addr)
);

/* sim/pid_tb.sv */
`timescale 1ns/1ps
`include "pid_consts.svh"

module pid_tb;

    localparam int N_SAMPLES = 48 + 160 + 64 + 48 + 32 + 64;
    localparam longint DOUT_MAX = 64'sd2147483647;
    localparam longint DOUT_MIN = -64'sd2147483648;

    logic clk_in = 1'b0;
    logic rst_n = 1'b0;
    logic in_credit;
    logic in_valid = 1'b0;
    pid_pkg::chan_t in_chan = '0;
    pid_pkg::sample_t in_sample = '0;
    logic cfg_valid = 1'b0;
    pid_pkg::cfg_addr_e cfg_addr = pid_pkg::SETPOINT;
    pid_pkg::chan_t cfg_chan = '0;
    logic [`PID_W_CFG-1:0] cfg_data = '0;
    logic out_valid;
    pid_pkg::chan_t out_chan;
    pid_pkg::dout_t out_data;
    logic out_credit = 1'b0;

    // Per-channel model state
    longint m_sp [`PID_N_CHAN];
    longint m_p [`PID_N_CHAN];
    longint m_i [`PID_N_CHAN];
    longint m_d [`PID_N_CHAN];
    longint m_e1 [`PID_N_CHAN];
    longint m_e2 [`PID_N_CHAN];
    longint m_prev [`PID_N_CHAN];
    bit m_inv [`PID_N_CHAN];

    // Expected results in output order, plus credit return schedule
    int exp_chan [$];
    longint exp_data [$];
    int exp_cyc [$];
    int ret_q [$];

    int cyc = 0;
    int credits = 0;
    int errors = 0;
    int sent = 0;
    int outputs = 0;
    int in_credits = 0;
    int returned = 0;
    int voided_model = 0;
    int sat_hits = 0;
    int ret_extra = 0;

    always #10 clk_in = ~clk_in;

    pid_top i_pid_top (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .in_credit  (in_credit),
        .in_valid   (in_valid),
        .in_chan    (in_chan),
        .in_sample  (in_sample),
        .cfg_valid  (cfg_valid),
        .cfg_addr   (cfg_addr),
        .cfg_chan   (cfg_chan),
        .cfg_data   (cfg_data),
        .out_valid  (out_valid),
        .out_chan   (out_chan),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic longint calc_error(longint sp, longint x, bit inv);
        longint e;
        e = sp - x;
        // Ones' complement of e is -e-1
        return inv ? -e - 1 : e;
    endfunction

    function automatic longint calc_output(longint p, longint i, longint d, longint e,
                                           longint e1, longint e2, longint prev);
        longint sum;
        sum = prev + (p + i + d) * e + (-p - 2 * d) * e1 + d * e2;
        if (sum > DOUT_MAX) return DOUT_MAX;
        if (sum < DOUT_MIN) return DOUT_MIN;
        return sum;
    endfunction

    function automatic int rand_int(int lo, int hi);
        return lo + int'($urandom_range(hi - lo));
    endfunction

    // Keep a sample inside the 18-bit signed range
    function automatic longint clamp_sample(longint x);
        if (x > 131071) return 131071;
        if (x < -131072) return -131072;
        return x;
    endfunction

    // Clear voids items driven up to 3 cycles before the write
    task automatic apply_clear(int ch);
        for (int k = exp_chan.size() - 1; k >= 0; k--) begin
            if (exp_chan[k] == ch && exp_cyc[k] >= cyc - 3) begin
                exp_chan.delete(k);
                exp_data.delete(k);
                exp_cyc.delete(k);
                voided_model++;
            end
        end
        m_e1[ch] = 0;
        m_e2[ch] = 0;
        m_prev[ch] = 0;
    endtask

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------
    task automatic write_cfg(pid_pkg::cfg_addr_e addr, int ch, longint val);
        @(posedge clk_in);
        in_valid <= 1'b0;
        cfg_valid <= 1'b1;
        cfg_addr <= addr;
        cfg_chan <= pid_pkg::chan_t'(ch);
        cfg_data <= 32'(val);
        case (addr)
            pid_pkg::SETPOINT:  m_sp[ch] = val;
            pid_pkg::P_COEF:    m_p[ch] = val;
            pid_pkg::I_COEF:    m_i[ch] = val;
            pid_pkg::D_COEF:    m_d[ch] = val;
            pid_pkg::INV_ERROR: m_inv[ch] = val[0];
            default: ;
        endcase
        if (addr == pid_pkg::CLEAR && val[0]) apply_clear(ch);
        @(posedge clk_in);
        cfg_valid <= 1'b0;
    endtask

    task automatic configure(int ch, int sp, int p, int i, int d, int inv);
        write_cfg(pid_pkg::SETPOINT, ch, sp);
        write_cfg(pid_pkg::P_COEF, ch, p);
        write_cfg(pid_pkg::I_COEF, ch, i);
        write_cfg(pid_pkg::D_COEF, ch, d);
        write_cfg(pid_pkg::INV_ERROR, ch, inv);
    endtask

    // One sample, only while a credit is held
    task automatic send_sample(int ch, longint x);
        longint e;
        longint y;
        @(posedge clk_in);
        while (credits == 0) begin
            in_valid <= 1'b0;
            @(posedge clk_in);
        end
        in_valid <= 1'b1;
        in_chan <= pid_pkg::chan_t'(ch);
        in_sample <= pid_pkg::sample_t'(x);
        credits--;
        sent++;
        e = calc_error(m_sp[ch], x, m_inv[ch]);
        y = calc_output(m_p[ch], m_i[ch], m_d[ch], e, m_e1[ch], m_e2[ch], m_prev[ch]);
        m_e2[ch] = m_e1[ch];
        m_e1[ch] = e;
        m_prev[ch] = y;
        exp_chan.push_back(ch);
        exp_data.push_back(y);
        exp_cyc.push_back(cyc);
    endtask

    // Round-robin channels; negative spread mirrors the setpoint
    task automatic run_stream(int n, int spread, int clear_at);
        int ch;
        longint x;
        for (int k = 0; k < n; k++) begin
            ch = k % `PID_N_CHAN;
            if (spread < 0) x = -m_sp[ch];
            else x = m_sp[ch] + rand_int(-spread, spread);
            send_sample(ch, clamp_sample(x));
            if (k == clear_at) write_cfg(pid_pkg::CLEAR, ch, 1);
        end
    endtask

    task automatic drain();
        @(posedge clk_in);
        in_valid <= 1'b0;
        while (exp_chan.size() > 0 || ret_q.size() > 0) @(posedge clk_in);
        repeat (8) @(posedge clk_in);
    endtask

    // ----------------------------------------
    // Downstream credit return
    // ----------------------------------------
    always @(posedge clk_in) begin
        out_credit <= 1'b0;
        if (ret_q.size() > 0 && ret_q[0] <= cyc) begin
            out_credit <= 1'b1;
            void'(ret_q.pop_front());
            returned++;
        end
    end

    // Monitor and compare, sampled mid-cycle
    always @(negedge clk_in) begin
        int exp_ch;
        longint exp_d;
        int due;
        cyc++;
        if (rst_n && in_credit) begin
            credits++;
            in_credits++;
        end
        if (rst_n && out_valid) begin
            outputs++;
            if (out_data == DOUT_MAX || out_data == DOUT_MIN) sat_hits++;
            if (exp_chan.size() == 0) begin
                errors++;
                $display("ERROR: output on channel %0d with no sample pending", out_chan);
            end else begin
                exp_ch = exp_chan.pop_front();
                exp_d = exp_data.pop_front();
                void'(exp_cyc.pop_front());
                if (out_chan != exp_ch || out_data != exp_d) begin
                    errors++;
                    $display("MISMATCH at %0t: chan %0d data %0d, expected chan %0d data %0d",
                             $time, out_chan, out_data, exp_ch, exp_d);
                end
            end
            // At most one credit per cycle, in order
            due = cyc + int'($urandom_range(3)) + ret_extra;
            if (ret_q.size() > 0 && due <= ret_q[$]) due = ret_q[$] + 1;
            ret_q.push_back(due);
            if (outputs - returned > `PID_OUT_CREDITS) begin
                errors++;
                $display("ERROR: more outputs outstanding than downstream credits");
            end
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'hd4dc60ce));
        repeat (10) @(posedge clk_in);
        rst_n <= 1'b1;
        // Proportional only
        for (int ch = 0; ch < `PID_N_CHAN; ch++)
            configure(ch, rand_int(-50000, 50000), rand_int(-255, 255), 0, 0, 0);
        run_stream(48, 100000, -1);
        drain();
        // Full PID, small errors of both signs
        for (int ch = 0; ch < `PID_N_CHAN; ch++)
            configure(ch, rand_int(-50000, 50000), rand_int(-127, 127),
                      rand_int(-127, 127), rand_int(-127, 127), 0);
        run_stream(160, 4000, -1);
        drain();
        // Inverted error on odd channels
        for (int ch = 0; ch < `PID_N_CHAN; ch++)
            configure(ch, rand_int(-50000, 50000), rand_int(-255, 255),
                      rand_int(-63, 63), rand_int(-63, 63), ch % 2);
        run_stream(64, 100000, -1);
        drain();
        // Saturation, even channels high and odd channels low
        for (int ch = 0; ch < `PID_N_CHAN; ch++)
            configure(ch, (ch % 2) ? -131072 : 131071, 32767, 32767, 0, 0);
        sat_hits = 0;
        run_stream(48, -1, -1);
        drain();
        if (sat_hits != 48) begin
            errors++;
            $display("ERROR: only %0d of 48 outputs reached the output limits", sat_hits);
        end
        // Clear while idle
        for (int ch = 0; ch < `PID_N_CHAN; ch++)
            configure(ch, rand_int(-50000, 50000), rand_int(-127, 127),
                      rand_int(-127, 127), rand_int(-127, 127), 0);
        run_stream(16, 4000, -1);
        drain();
        write_cfg(pid_pkg::CLEAR, 2, 1);
        run_stream(16, 4000, -1);
        drain();
        // Slow credit return, clear of channel 5 in flight
        ret_extra = 10;
        run_stream(64, 4000, 29);
        drain();
        ret_extra = 0;
        if (sent - outputs != voided_model || voided_model != 1) begin
            errors++;
            $display("ERROR: %0d samples voided, model expects %0d", sent - outputs,
                     voided_model);
        end
        if (in_credits != `PID_OUT_CREDITS + returned + (sent - outputs)) begin
            errors++;
            $display("ERROR: %0d input credits received, %0d returned, %0d voided",
                     in_credits, returned, sent - outputs);
        end
        $display("Samples %0d, outputs %0d, errors %0d", sent, outputs, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (N_SAMPLES * 8 + 2000) @(posedge clk_in);
        $display("Timeout: run did not finish within %0d cycles", N_SAMPLES * 8 + 2000);
        $display("Verification failed");
        $finish;
    end

endmodule

/* all.f */
+incdir+src
src/pid_pkg.sv
src/pid_stage_if.sv
src/pid_config.sv
src/pid_error_stage.sv
src/pid_accum_stage.sv
src/pid_top.sv
sim/pid_props.sv
sim/pid_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module pid_tb -f all.f \
    -o pid_sim || exit 1
out="$(./obj_dir/pid_sim)"
echo "$out"
echo "$out" | grep -q "Verification passed" && exit 0 || exit 1
